// ==== src/storeBufPkg.sv ====
`default_nettype none

package storeBufPkg;

  // Store and load address width
  localparam int addrWidth = 8;

  // Store data width
  localparam int dataWidth = 16;

  // Idle cycles on the memory port after each accepted write
  localparam int gapCycles = 2;

  // Wide enough to hold gapCycles
  localparam int gapCountWidth = 2;

  // One pending store, address in the upper bits
  typedef struct packed {
    logic [addrWidth-1:0] addr;
    logic [dataWidth-1:0] data;
  } storeEntry;

endpackage

`default_nettype wire

// ==== src/storeFifo4.sv ====
`default_nettype none

module storeFifo4 #(
  parameter type payloadType = logic [31:0]
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       push,
  input  logic       pop,
  input  payloadType inData,
  output payloadType outData,
  output logic       full,
  output logic       empty,
  output payloadType entry0,
  output payloadType entry1,
  output payloadType entry2,
  output payloadType entry3,
  output logic [3:0] entryValid,
  output logic [1:0] nextRdPtr
);

  logic [1:0] wrPtr;
  logic [1:0] rdPtr;
  logic [1:0] nextWrPtr;
  logic       nextEmpty;
  logic       nextFull;
  logic [3:0] nextValid;
  payloadType mem [4];

  // Pointers advance by one per push or pop
  assign nextWrPtr = push ? wrPtr + 2'd1 : wrPtr;
  assign nextRdPtr = pop ? rdPtr + 2'd1 : rdPtr;

  always_ff @(posedge clk) begin
    if (reset) begin
      wrPtr <= 2'd0;
      rdPtr <= 2'd0;
    end else begin
      wrPtr <= nextWrPtr;
      rdPtr <= nextRdPtr;
    end
  end

  // Equal pointers mean empty or full, the last operation decides which
  always_comb begin
    if ((nextWrPtr == nextRdPtr) && pop && !push)
      nextEmpty = 1'b1;
    else if (nextWrPtr != nextRdPtr)
      nextEmpty = 1'b0;
    else
      nextEmpty = empty;

    if ((nextWrPtr == nextRdPtr) && push && !pop)
      nextFull = 1'b1;
    else if (nextWrPtr != nextRdPtr)
      nextFull = 1'b0;
    else
      nextFull = full;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      empty <= 1'b1;
      full  <= 1'b0;
    end else begin
      empty <= nextEmpty;
      full  <= nextFull;
    end
  end

  always_ff @(posedge clk) begin
    if (push)
      mem[wrPtr] <= inData;
  end

  assign entry0 = mem[0];
  assign entry1 = mem[1];
  assign entry2 = mem[2];
  assign entry3 = mem[3];

  // Head of queue
  always_comb begin
    case (rdPtr)
      2'd0: outData = entry0;
      2'd1: outData = entry1;
      2'd2: outData = entry2;
      default: outData = entry3;
    endcase
  end

  // Per-entry valid bits
  always_comb begin
    nextValid = entryValid;
    if (push)
      nextValid[wrPtr] = 1'b1;
    if (pop)
      nextValid[rdPtr] = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (reset)
      entryValid <= 4'b0000;
    else
      entryValid <= nextValid;
  end

endmodule

`default_nettype wire

// ==== src/gapTimer.sv ====
`default_nettype none

module gapTimer (
  input  logic clk,
  input  logic reset,
  input  logic start,
  output logic done
);

  logic [storeBufPkg::gapCountWidth-1:0] count;

  // Count holds the idle cycles still to come after the current one,
  // so the last gap cycle already sees done
  always_ff @(posedge clk) begin
    if (reset)
      count <= '0;
    else if (start)
      count <= storeBufPkg::gapCountWidth'(storeBufPkg::gapCycles - 1);
    else if (count != '0)
      count <= count - 1'b1;
  end

  assign done = (count == '0);

endmodule

`default_nettype wire

// ==== src/drainCtrl.sv ====
`default_nettype none

module drainCtrl (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              empty,
  input  storeBufPkg::storeEntry            headEntry,
  input  logic                              memReady,
  input  logic                              timerDone,
  output logic                              memValid,
  output logic [storeBufPkg::addrWidth-1:0] memAddr,
  output logic [storeBufPkg::dataWidth-1:0] memData,
  output logic                              pop,
  output logic                              timerStart
);

  typedef enum logic {
    Idle,
    Gap
  } drainState;

  drainState state;
  drainState nextState;

  // Head entry goes straight to the port, queue holds it until popped
  assign memValid = (state == Idle) && !empty;
  assign memAddr  = headEntry.addr;
  assign memData  = headEntry.data;

  assign pop        = memValid && memReady;
  assign timerStart = pop;

  always_comb begin
    nextState = state;
    case (state)
      Idle: begin
        if (pop)
          nextState = Gap;
      end
      Gap: begin
        if (timerDone)
          nextState = Idle;
      end
      default: nextState = Idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset)
      state <= Idle;
    else
      state <= nextState;
  end

endmodule

`default_nettype wire

// ==== src/hazardCheck.sv ====
`default_nettype none

module hazardCheck (
  input  logic [storeBufPkg::addrWidth-1:0] loadAddr,
  input  storeBufPkg::storeEntry            entry0,
  input  storeBufPkg::storeEntry            entry1,
  input  storeBufPkg::storeEntry            entry2,
  input  storeBufPkg::storeEntry            entry3,
  input  logic [3:0]                        entryValid,
  output logic                              loadReady
);

  storeBufPkg::storeEntry entries [4];
  logic [3:0]             addrMatch;

  assign entries[0] = entry0;
  assign entries[1] = entry1;
  assign entries[2] = entry2;
  assign entries[3] = entry3;

  // Only valid entries count as pending
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      addrMatch[i] = entryValid[i] && (entries[i].addr == loadAddr);
    end
  end

  assign loadReady = ~|addrMatch;

endmodule

`default_nettype wire

// ==== src/storeBuffer.sv ====
`default_nettype none

module storeBuffer (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              storeValid,
  input  logic [storeBufPkg::addrWidth-1:0] storeAddr,
  input  logic [storeBufPkg::dataWidth-1:0] storeData,
  output logic                              storeReady,
  output logic                              memValid,
  output logic [storeBufPkg::addrWidth-1:0] memAddr,
  output logic [storeBufPkg::dataWidth-1:0] memData,
  input  logic                              memReady,
  input  logic                              loadValid,
  input  logic [storeBufPkg::addrWidth-1:0] loadAddr,
  output logic                              loadReady
);

  storeBufPkg::storeEntry inEntry;
  storeBufPkg::storeEntry headEntry;
  storeBufPkg::storeEntry entry0;
  storeBufPkg::storeEntry entry1;
  storeBufPkg::storeEntry entry2;
  storeBufPkg::storeEntry entry3;
  logic [3:0]             entryValid;
  logic                   push;
  logic                   pop;
  logic                   full;
  logic                   empty;
  logic                   timerStart;
  logic                   timerDone;

  assign inEntry    = '{addr: storeAddr, data: storeData};
  assign storeReady = ~full;
  assign push       = storeValid && storeReady;

  // Next read pointer has no user here
  storeFifo4 #(
    .payloadType(storeBufPkg::storeEntry)
  ) fifo0 (
    .clk       (clk),
    .reset     (reset),
    .push      (push),
    .pop       (pop),
    .inData    (inEntry),
    .outData   (headEntry),
    .full      (full),
    .empty     (empty),
    .entry0    (entry0),
    .entry1    (entry1),
    .entry2    (entry2),
    .entry3    (entry3),
    .entryValid(entryValid),
    .nextRdPtr ()
  );

  drainCtrl drain0 (
    .clk       (clk),
    .reset     (reset),
    .empty     (empty),
    .headEntry (headEntry),
    .memReady  (memReady),
    .timerDone (timerDone),
    .memValid  (memValid),
    .memAddr   (memAddr),
    .memData   (memData),
    .pop       (pop),
    .timerStart(timerStart)
  );

  gapTimer timer0 (
    .clk  (clk),
    .reset(reset),
    .start(timerStart),
    .done (timerDone)
  );

  // Loads are checked against entries already queued, not the incoming store
  hazardCheck hazard0 (
    .loadAddr  (loadAddr),
    .entry0    (entry0),
    .entry1    (entry1),
    .entry2    (entry2),
    .entry3    (entry3),
    .entryValid(entryValid),
    .loadReady (loadReady)
  );

endmodule

`default_nettype wire

// ==== verif/storeBufferProperties.sv ====
`default_nettype none

module storeBufferProperties (
  input logic                              clk,
  input logic                              reset,
  input logic                              memValid,
  input logic                              memReady,
  input logic [storeBufPkg::addrWidth-1:0] memAddr,
  input logic [storeBufPkg::dataWidth-1:0] memData,
  input logic                              storeReady,
  input logic                              loadReady,
  input logic                              empty
);

  int unsigned                     failCount = 0;
  logic [storeBufPkg::gapCycles:0] writeHist;
  logic                            memWrite;

  assign memWrite = memValid && memReady;

  // Bit k set when a write was accepted k+1 cycles back
  always_ff @(posedge clk) begin
    if (reset)
      writeHist <= '0;
    else
      writeHist <= {writeHist[storeBufPkg::gapCycles-1:0], memWrite};
  end

  resetState: assert property (@(posedge clk)
    $fell(reset) |-> !memValid && storeReady && loadReady)
    else begin
      failCount++;
      $error("Outputs not in their reset state in the first cycle after reset");
    end

  gapIdle: assert property (@(posedge clk) disable iff (reset)
    |writeHist[storeBufPkg::gapCycles-1:0] |-> !memValid)
    else begin
      failCount++;
      $error("memValid high inside the idle gap after a write");
    end

  // Gap is over, so a pending entry must be offered again
  gapEnd: assert property (@(posedge clk) disable iff (reset)
    writeHist[storeBufPkg::gapCycles] |-> memValid || empty)
    else begin
      failCount++;
      $error("memValid still low after the idle gap with entries pending");
    end

  holdStable: assert property (@(posedge clk) disable iff (reset)
    memValid && !memReady |=> memValid && $stable(memAddr) && $stable(memData))
    else begin
      failCount++;
      $error("Memory write changed while stalled by memReady");
    end

endmodule

bind storeBuffer storeBufferProperties props0 (.*);

`default_nettype wire

// ==== verif/storeBufferTb.sv ====
`default_nettype none

module storeBufferTb;

  logic                              clk = 1'b0;
  logic                              reset;
  logic                              storeValid;
  logic [storeBufPkg::addrWidth-1:0] storeAddr;
  logic [storeBufPkg::dataWidth-1:0] storeData;
  logic                              storeReady;
  logic                              memValid;
  logic [storeBufPkg::addrWidth-1:0] memAddr;
  logic [storeBufPkg::dataWidth-1:0] memData;
  logic                              memReady;
  logic                              loadValid;
  logic [storeBufPkg::addrWidth-1:0] loadAddr;
  logic                              loadReady;

  // Stores accepted but not yet written, oldest first
  storeBufPkg::storeEntry pending [$];

  int unsigned numStores = 200;
  int unsigned storesSent = 0;
  int unsigned writesSeen = 0;
  int unsigned errCount = 0;
  int unsigned lowLeft = 0;

  always #10 clk = ~clk;

  storeBuffer dut0 (
    .clk       (clk),
    .reset     (reset),
    .storeValid(storeValid),
    .storeAddr (storeAddr),
    .storeData (storeData),
    .storeReady(storeReady),
    .memValid  (memValid),
    .memAddr   (memAddr),
    .memData   (memData),
    .memReady  (memReady),
    .loadValid (loadValid),
    .loadAddr  (loadAddr),
    .loadReady (loadReady)
  );

  // Small address range so loads often hit pending stores
  task automatic driveCycle();
    storeValid = (storesSent < numStores) && ($urandom_range(0, 2) != 0);
    storeAddr  = storeBufPkg::addrWidth'($urandom_range(0, 7));
    storeData  = storeBufPkg::dataWidth'($urandom());
    loadValid  = 1'($urandom_range(0, 1));
    loadAddr   = storeBufPkg::addrWidth'($urandom_range(0, 7));
    if (lowLeft != 0) begin
      memReady = 1'b0;
      lowLeft--;
    end else if ($urandom_range(0, 9) == 0) begin
      memReady = 1'b0;
      lowLeft  = $urandom_range(2, 6);
    end else begin
      memReady = 1'b1;
    end
  endtask

  function automatic logic loadAllowed(input logic [storeBufPkg::addrWidth-1:0] addr);
    foreach (pending[i]) begin
      if (pending[i].addr == addr)
        return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic checkWrite();
    storeBufPkg::storeEntry expected;
    if (pending.size() == 0) begin
      errCount++;
      $display("Memory write of address %h with no store pending", memAddr);
    end else begin
      expected = pending.pop_front();
      writesSeen++;
      assert (memAddr == expected.addr && memData == expected.data) else begin
        errCount++;
        $display("Error writeOrder: expected %h/%h, actual %h/%h",
                 expected.addr, expected.data, memAddr, memData);
      end
    end
  endtask

  // Outputs are settled by the falling edge
  always @(negedge clk) begin
    if (!reset) begin
      assert (storeReady == (pending.size() < 4)) else begin
        errCount++;
        $display("Error storeReady: expected %b, actual %b", pending.size() < 4, storeReady);
      end
      if (loadValid) begin
        assert (loadReady == loadAllowed(loadAddr)) else begin
          errCount++;
          $display("Error loadReady: expected %b, actual %b", loadAllowed(loadAddr), loadReady);
        end
      end
      if (memValid && memReady)
        checkWrite();
      // Same-cycle store joins the scoreboard only after the load check
      if (storeValid && storeReady) begin
        pending.push_back('{addr: storeAddr, data: storeData});
        storesSent++;
      end
    end
  end

  initial begin
    void'($urandom(32'h21bb_ce91));
    reset      = 1'b1;
    storeValid = 1'b0;
    storeAddr  = '0;
    storeData  = '0;
    memReady   = 1'b0;
    loadValid  = 1'b0;
    loadAddr   = '0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    while (writesSeen < numStores) begin
      @(posedge clk);
      #1;
      driveCycle();
    end
    // Let the last gap pass the bound assertions
    repeat (storeBufPkg::gapCycles + 2) @(posedge clk);
    $display("Summary: %0d check errors, %0d assertion errors",
             errCount, dut0.props0.failCount);
    if (errCount == 0 && dut0.props0.failCount == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

  initial begin
    repeat (8 + numStores * (storeBufPkg::gapCycles + 8) + 200) @(posedge clk);
    $display("Timeout: the memory writes did not finish in time");
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
src/storeBufPkg.sv
src/storeFifo4.sv
src/gapTimer.sv
src/drainCtrl.sv
src/hazardCheck.sv
src/storeBuffer.sv
verif/storeBufferProperties.sv
verif/storeBufferTb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module storeBufferTb \
		-Mdir obj_dir -f list.f
	./obj_dir/VstoreBufferTb +verilator+error+limit+1000 | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
